// File: hw/boot_rom.sv
`timescale 1ns/100ps

module boot_rom import soc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  stb_i,
  input  addr_t adr_i,
  output data_t dat_o,
  output logic  ack_o
);

  logic [RomIdxBits-1:0] idx;
  logic                  ack_q;
  data_t                 dat_q;

  // word index inside the rom
  assign idx = adr_i[WordAddrLsb +: RomIdxBits];

  // --------------------
  // handshake
  // --------------------
  // one ack per access, writes get the same answer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= stb_i & ~ack_q;
    end
  end

  // content comes from the package rule
  always_ff @(posedge clk_i) begin
    if (stb_i && !ack_q) begin
      dat_q <= boot_word(int'(idx));
    end
  end

  assign ack_o = ack_q;
  assign dat_o = dat_q;

endmodule

// File: hw/clint_timer.sv
`timescale 1ns/100ps

module clint_timer import soc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  rtc_i,
  input  logic  stb_i,
  input  logic  we_i,
  input  addr_t adr_i,
  input  data_t dat_i,
  output data_t dat_o,
  output logic  ack_o,
  output logic  timer_irq_o,
  output logic  ipi_o
);

  logic [2:0]  rtc_q;
  logic        rtc_rise;
  time_t       mtime_q;
  time_t       mtimecmp_q;
  logic        msip_q;
  logic        ack_q;
  logic        access;
  logic        wr_en;
  logic [15:0] offset;
  logic        sel_msip;
  logic        sel_mtimecmp;
  logic        sel_mtime;
  data_t       rd_data;
  data_t       dat_q;

  // --------------------
  // rtc edge detect
  // --------------------
  // two sync flops plus one for the previous value
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rtc_q <= '0;
    end else begin
      rtc_q <= {rtc_q[1:0], rtc_i};
    end
  end

  assign rtc_rise = rtc_q[1] & ~rtc_q[2];

  // --------------------
  // register decode
  // --------------------
  // region offset, byte lanes ignored
  assign offset       = adr_i[15:0];
  assign sel_msip     = offset[15:WordAddrLsb] == MsipOffset[15:WordAddrLsb];
  assign sel_mtimecmp = offset[15:WordAddrLsb] == MtimecmpOffset[15:WordAddrLsb];
  assign sel_mtime    = offset[15:WordAddrLsb] == MtimeOffset[15:WordAddrLsb];

  assign access = stb_i & ~ack_q;
  assign wr_en  = access & we_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q      <= 1'b0;
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
    end else begin
      ack_q <= access;
      if (wr_en && sel_msip) begin
        msip_q <= dat_i[0];
      end
      if (wr_en && sel_mtimecmp) begin
        mtimecmp_q <= dat_i;
      end
      // bus write wins over a tick in the same cycle
      if (wr_en && sel_mtime) begin
        mtime_q <= dat_i;
      end else if (rtc_rise) begin
        mtime_q <= mtime_q + time_t'(1);
      end
    end
  end

  // unmapped offsets read zero
  always_comb begin
    rd_data = '0;
    if (sel_msip) begin
      rd_data = {31'b0, msip_q};
    end else if (sel_mtimecmp) begin
      rd_data = mtimecmp_q;
    end else if (sel_mtime) begin
      rd_data = mtime_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      dat_q <= rd_data;
    end
  end

  assign dat_o       = dat_q;
  assign ack_o       = ack_q;
  assign ipi_o       = msip_q;
  assign timer_irq_o = mtime_q >= mtimecmp_q;

  // tick that brings mtime up to the compare value raises the irq
  a_timer_irq: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rtc_rise && !wr_en && (mtime_q + time_t'(1) == mtimecmp_q) |=> timer_irq_o);

endmodule

// File: hw/debug_req_gate.sv
`timescale 1ns/100ps

module debug_req_gate import soc_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic debug_req_i,
  output logic debug_req_o
);

  localparam int unsigned CntBits = $clog2(DebugDelayCycles + 1);

  logic [CntBits-1:0] cnt_q;
  logic               open;

  // window lets boot code run before a halt request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= CntBits'(DebugDelayCycles);
    end else if (!open) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // counter parks at zero
  assign open        = cnt_q == '0;
  assign debug_req_o = open & debug_req_i;

endmodule

// File: hw/soc_harness_top.sv
`timescale 1ns/100ps

module soc_harness_top import soc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  rtc_i,
  input  logic  wb_cyc_i,
  input  logic  wb_stb_i,
  input  logic  wb_we_i,
  input  addr_t wb_adr_i,
  input  data_t wb_dat_i,
  input  sel_t  wb_sel_i,
  input  logic  debug_req_i,
  output data_t wb_dat_o,
  output logic  wb_ack_o,
  output logic  wb_err_o,
  output logic  timer_irq_o,
  output logic  ipi_o,
  output logic  debug_req_o
);

  logic  rom_stb;
  logic  sram_stb;
  logic  clint_stb;
  logic  rom_ack;
  logic  sram_ack;
  logic  clint_ack;
  data_t rom_dat;
  data_t sram_dat;
  data_t clint_dat;

  // --------------------
  // bus fabric
  // --------------------
  wb_addr_decode i_decode (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .cyc_i       ( wb_cyc_i  ),
    .stb_i       ( wb_stb_i  ),
    .adr_i       ( wb_adr_i  ),
    .rom_ack_i   ( rom_ack   ),
    .sram_ack_i  ( sram_ack  ),
    .clint_ack_i ( clint_ack ),
    .rom_dat_i   ( rom_dat   ),
    .sram_dat_i  ( sram_dat  ),
    .clint_dat_i ( clint_dat ),
    .rom_stb_o   ( rom_stb   ),
    .sram_stb_o  ( sram_stb  ),
    .clint_stb_o ( clint_stb ),
    .dat_o       ( wb_dat_o  ),
    .ack_o       ( wb_ack_o  ),
    .err_o       ( wb_err_o  )
  );

  // --------------------
  // targets
  // --------------------
  boot_rom i_rom (
    .clk_i   ( clk_i    ),
    .rst_n_i ( rst_n_i  ),
    .stb_i   ( rom_stb  ),
    .adr_i   ( wb_adr_i ),
    .dat_o   ( rom_dat  ),
    .ack_o   ( rom_ack  )
  );

  wb_sram i_sram (
    .clk_i   ( clk_i    ),
    .rst_n_i ( rst_n_i  ),
    .stb_i   ( sram_stb ),
    .we_i    ( wb_we_i  ),
    .adr_i   ( wb_adr_i ),
    .dat_i   ( wb_dat_i ),
    .sel_i   ( wb_sel_i ),
    .dat_o   ( sram_dat ),
    .ack_o   ( sram_ack )
  );

  clint_timer i_clint (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .rtc_i       ( rtc_i       ),
    .stb_i       ( clint_stb   ),
    .we_i        ( wb_we_i     ),
    .adr_i       ( wb_adr_i    ),
    .dat_i       ( wb_dat_i    ),
    .dat_o       ( clint_dat   ),
    .ack_o       ( clint_ack   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  // masks debug requests during boot
  debug_req_gate i_dbg_gate (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// File: hw/soc_pkg.sv
package soc_pkg;

  // --------------------
  // bus types
  // --------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  sel_t;
  // mtime and mtimecmp width
  typedef logic [31:0] time_t;

  // byte offset bits inside a word
  localparam int unsigned WordAddrLsb = 2;

  // --------------------
  // address map
  // --------------------
  localparam addr_t       RomBase     = 32'h0000_0000;
  localparam int unsigned RomWords    = 64;
  localparam int unsigned RomIdxBits  = $clog2(RomWords);
  localparam addr_t       RomLength   = addr_t'(RomWords << WordAddrLsb);

  localparam addr_t ClintBase      = 32'h0200_0000;
  localparam addr_t ClintLength    = 32'h0001_0000;
  // register offsets inside the clint region
  localparam addr_t MsipOffset     = 32'h0000_0000;
  localparam addr_t MtimecmpOffset = 32'h0000_4000;
  localparam addr_t MtimeOffset    = 32'h0000_BFF8;

  localparam addr_t       SramBase    = 32'h1000_0000;
  localparam int unsigned SramWords   = 32;
  localparam int unsigned SramIdxBits = $clog2(SramWords);
  localparam addr_t       SramLength  = addr_t'(SramWords << WordAddrLsb);

  // cycles the debug request stays masked after reset
  localparam int unsigned DebugDelayCycles = 500;

  // --------------------
  // boot rom content
  // --------------------
  // upper half is a fixed tag, lower half the word index
  function automatic data_t boot_word(input int unsigned idx);
    return {16'hB007, idx[15:0]};
  endfunction

endpackage

// File: hw/wb_addr_decode.sv
`timescale 1ns/100ps

module wb_addr_decode import soc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  cyc_i,
  input  logic  stb_i,
  input  addr_t adr_i,
  input  logic  rom_ack_i,
  input  logic  sram_ack_i,
  input  logic  clint_ack_i,
  input  data_t rom_dat_i,
  input  data_t sram_dat_i,
  input  data_t clint_dat_i,
  output logic  rom_stb_o,
  output logic  sram_stb_o,
  output logic  clint_stb_o,
  output data_t dat_o,
  output logic  ack_o,
  output logic  err_o
);

  logic req;
  logic rom_hit;
  logic sram_hit;
  logic clint_hit;
  logic any_hit;
  logic err_q;

  // base aligned to a power-of-two length, so masking is enough
  function automatic logic in_range(input addr_t adr, input addr_t base, input addr_t len);
    return (adr & ~(len - addr_t'(1))) == base;
  endfunction

  // --------------------
  // target select
  // --------------------
  assign req       = cyc_i & stb_i;
  assign rom_hit   = in_range(adr_i, RomBase, RomLength);
  assign sram_hit  = in_range(adr_i, SramBase, SramLength);
  assign clint_hit = in_range(adr_i, ClintBase, ClintLength);
  assign any_hit   = rom_hit | sram_hit | clint_hit;

  assign rom_stb_o   = req & rom_hit;
  assign sram_stb_o  = req & sram_hit;
  assign clint_stb_o = req & clint_hit;

  // --------------------
  // unmapped access
  // --------------------
  // error answer one cycle after the request, single pulse
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req & ~any_hit & ~err_q;
    end
  end

  assign err_o = err_q;

  // --------------------
  // response mux
  // --------------------
  // request fields are still held in the ack cycle
  assign ack_o = (rom_stb_o & rom_ack_i) | (sram_stb_o & sram_ack_i) |
                 (clint_stb_o & clint_ack_i);

  always_comb begin
    dat_o = '0;
    if (rom_hit) begin
      dat_o = rom_dat_i;
    end else if (sram_hit) begin
      dat_o = sram_dat_i;
    end else if (clint_hit) begin
      dat_o = clint_dat_i;
    end
  end

  // regions must not overlap
  a_one_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({rom_stb_o, sram_stb_o, clint_stb_o}));

  // target ack and decode error are exclusive
  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(ack_o && err_o));

endmodule

// File: hw/wb_sram.sv
`timescale 1ns/100ps

module wb_sram import soc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  stb_i,
  input  logic  we_i,
  input  addr_t adr_i,
  input  data_t dat_i,
  input  sel_t  sel_i,
  output data_t dat_o,
  output logic  ack_o
);

  data_t                  mem [SramWords];
  logic [SramIdxBits-1:0] idx;
  logic                   ack_q;
  logic                   access;
  data_t                  dat_q;

  assign idx    = adr_i[WordAddrLsb +: SramIdxBits];
  // first cycle of the request only
  assign access = stb_i & ~ack_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // --------------------
  // storage
  // --------------------
  // write lands on the edge that raises ack
  always_ff @(posedge clk_i) begin
    if (access && we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (sel_i[b]) begin
          mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
        end
      end
    end else if (access) begin
      dat_q <= mem[idx];
    end
  end

  assign ack_o = ack_q;
  assign dat_o = dat_q;

  // held request must not produce a second ack
  a_single_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_o |=> !ack_o);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the harness testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_soc_harness \
  -f sources.f \
  --Mdir "$build_dir" -o tb_soc_harness

"./$build_dir/tb_soc_harness" | tee "$log_file"

if grep -q "Verification failed" "$log_file"; then
  echo "simulation failed, see $log_file"
  exit 1
fi

echo "simulation log in $log_file"

// File: sources.f
hw/soc_pkg.sv
hw/wb_addr_decode.sv
hw/boot_rom.sv
hw/wb_sram.sv
hw/clint_timer.sv
hw/debug_req_gate.sv
hw/soc_harness_top.sv
testbench/tb_soc_harness.sv

// File: testbench/tb_soc_harness.sv
`timescale 1ns/100ps

module tb_soc_harness import soc_pkg::*;;

  localparam int unsigned WaitLimit = 20;

  logic  clk_i;
  logic  rst_n_i;
  logic  rtc_i;
  logic  wb_cyc_i;
  logic  wb_stb_i;
  logic  wb_we_i;
  addr_t wb_adr_i;
  data_t wb_dat_i;
  sel_t  wb_sel_i;
  logic  debug_req_i;
  data_t wb_dat_o;
  logic  wb_ack_o;
  logic  wb_err_o;
  logic  timer_irq_o;
  logic  ipi_o;
  logic  debug_req_o;

  logic        req;
  logic        resp;
  logic        expect_err;
  logic        dbg_expect;
  int          since_rst;
  int          err_cnt;
  int          test_cnt;
  int          failed_tests;
  int          test_err_start;
  logic [31:0] lfsr;

  soc_harness_top i_dut (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .rtc_i       ( rtc_i       ),
    .wb_cyc_i    ( wb_cyc_i    ),
    .wb_stb_i    ( wb_stb_i    ),
    .wb_we_i     ( wb_we_i     ),
    .wb_adr_i    ( wb_adr_i    ),
    .wb_dat_i    ( wb_dat_i    ),
    .wb_sel_i    ( wb_sel_i    ),
    .debug_req_i ( debug_req_i ),
    .wb_dat_o    ( wb_dat_o    ),
    .wb_ack_o    ( wb_ack_o    ),
    .wb_err_o    ( wb_err_o    ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       ),
    .debug_req_o ( debug_req_o )
  );

  always #50 clk_i = ~clk_i;

  // cycles since reset release, parked well past the debug window
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      since_rst <= 0;
    end else if (since_rst < 1000) begin
      since_rst <= since_rst + 1;
    end
  end

  assign req        = wb_cyc_i & wb_stb_i;
  assign resp       = wb_ack_o | wb_err_o;
  assign dbg_expect = debug_req_i && (since_rst >= int'(DebugDelayCycles));

  // --------------------
  // helpers
  // --------------------
  task automatic note_fail(input string msg);
    err_cnt++;
    $display("%s", msg);
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Verification failed");
    $finish;
  endtask

  task automatic check_value(input string name, input data_t got, input data_t exp);
    assert (got == exp) else note_fail($sformatf("Error %s: got %h, expected %h", name, got, exp));
  endtask

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic begin_test();
    test_err_start = err_cnt;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt == test_err_start) begin
      $display("test %-8s ok", name);
    end else begin
      failed_tests++;
      $display("test %-8s %0d errors", name, err_cnt - test_err_start);
    end
  endtask

  // --------------------
  // wishbone driver
  // --------------------
  // request held until ack or err, dropped in the next cycle
  task automatic wb_access(input logic we, input addr_t adr, input data_t dat,
                           input sel_t sel, output data_t rdat);
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    rdat   = '0;
    @(posedge clk_i);
    #1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    // sampled mid-cycle where outputs are settled
    while (!done && waited < int'(WaitLimit)) begin
      @(negedge clk_i);
      waited++;
      if (wb_ack_o || wb_err_o) begin
        done = 1'b1;
        rdat = wb_dat_o;
      end
    end
    if (!done) begin
      stop_on_timeout($sformatf("ack or err at address %h", adr));
    end else begin
      @(posedge clk_i);
      #1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
    end
  endtask

  task automatic wb_write(input addr_t adr, input data_t dat, input sel_t sel);
    data_t unused;
    wb_access(1'b1, adr, dat, sel, unused);
  endtask

  task automatic wb_read(input addr_t adr, output data_t rdat);
    wb_access(1'b0, adr, '0, 4'hF, rdat);
  endtask

  // high for two cycles, low, then room for the sync latency
  task automatic pulse_rtc();
    @(posedge clk_i);
    #1 rtc_i = 1'b1;
    repeat (2) @(posedge clk_i);
    #1 rtc_i = 1'b0;
    repeat (4) @(negedge clk_i);
  endtask

  // --------------------
  // bus and gate checks
  // --------------------
  a_resp_next_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(req) |=> resp)
    else note_fail("no ack or err one cycle after the request");

  a_no_early_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(req) |-> !resp)
    else note_fail("response in the same cycle as the request");

  a_resp_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp |=> !resp)
    else note_fail("response held for more than one cycle");

  a_resp_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp |-> req)
    else note_fail("response without a pending request");

  a_err_only_unmapped: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_err_o |-> expect_err)
    else note_fail("error response to a mapped address");

  a_ack_only_mapped: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_o |-> !expect_err)
    else note_fail("ack for an unmapped address");

  // low through the window, then a plain copy of the request
  a_debug_gate: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    debug_req_o == dbg_expect)
    else note_fail($sformatf("Error debug_req_o: got %h, expected %h",
                             $sampled(debug_req_o), $sampled(dbg_expect)));

  // --------------------
  // tests
  // --------------------
  task automatic run_rom_test();
    data_t       rd;
    logic [31:0] r;
    int          idx;
    begin_test();
    for (int i = 0; i < 8; i++) begin
      take_bits(6, r);
      // top word once, the rest random
      idx = (i == 0) ? int'(RomWords) - 1 : int'(r);
      wb_read(RomBase + addr_t'(idx << WordAddrLsb), rd);
      check_value("wb_dat_o", rd, {16'hB007, 16'(idx)});
    end
    take_bits(32, r);
    wb_write(RomBase + 32'h14, r, 4'hF);
    wb_read(RomBase + 32'h14, rd);
    check_value("wb_dat_o", rd, {16'hB007, 16'd5});
    end_test("rom");
  endtask

  task automatic run_sram_test();
    data_t       model [SramWords];
    int          idx [8];
    logic [31:0] r;
    data_t       d;
    sel_t        sel;
    data_t       rd;
    begin_test();
    for (int i = 0; i < 8; i++) begin
      take_bits(SramIdxBits, r);
      idx[i] = int'(r);
      take_bits(32, d);
      wb_write(SramBase + addr_t'(idx[i] << WordAddrLsb), d, 4'hF);
      model[idx[i]] = d;
    end
    // partial rewrite, unselected lanes keep the first word
    for (int i = 0; i < 8; i++) begin
      take_bits(32, d);
      take_bits(4, r);
      sel = r[3:0];
      if (sel == 4'h0 || sel == 4'hF) begin
        sel = 4'h6;
      end
      wb_write(SramBase + addr_t'(idx[i] << WordAddrLsb), d, sel);
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) begin
          model[idx[i]][8*b +: 8] = d[8*b +: 8];
        end
      end
    end
    for (int i = 0; i < 8; i++) begin
      wb_read(SramBase + addr_t'(idx[i] << WordAddrLsb), rd);
      check_value("wb_dat_o", rd, model[idx[i]]);
    end
    end_test("sram");
  endtask

  task automatic run_unmapped_test();
    data_t       rd;
    logic [31:0] d;
    begin_test();
    expect_err = 1'b1;
    wb_read(32'h3000_0000, rd);
    take_bits(32, d);
    // just past the rom
    wb_write(32'h0000_0100, d, 4'hF);
    expect_err = 1'b0;
    end_test("unmapped");
  endtask

  task automatic run_clint_test();
    data_t rd;
    begin_test();
    wb_write(ClintBase + MsipOffset, 32'h1, 4'hF);
    check_value("ipi_o", data_t'(ipi_o), 32'h1);
    wb_write(ClintBase + MsipOffset, 32'h0, 4'hF);
    check_value("ipi_o", data_t'(ipi_o), 32'h0);
    wb_write(ClintBase + MtimeOffset, 32'h0, 4'hF);
    wb_write(ClintBase + MtimecmpOffset, 32'h5, 4'hF);
    // irq stays low until the fifth tick
    for (int p = 0; p < 5; p++) begin
      check_value("timer_irq_o", data_t'(timer_irq_o), 32'h0);
      pulse_rtc();
    end
    check_value("timer_irq_o", data_t'(timer_irq_o), 32'h1);
    wb_read(ClintBase + MtimeOffset, rd);
    check_value("wb_dat_o", rd, 32'h5);
    end_test("clint");
  endtask

  task automatic run_debug_test();
    int waited;
    waited = 0;
    while (since_rst < int'(DebugDelayCycles) + 2 && waited < int'(DebugDelayCycles) + 50) begin
      @(negedge clk_i);
      waited++;
    end
    if (since_rst < int'(DebugDelayCycles) + 2) begin
      stop_on_timeout("the debug mask window to close");
    end else begin
      check_value("debug_req_o", data_t'(debug_req_o), 32'h1);
      @(posedge clk_i);
      #1 debug_req_i = 1'b0;
      @(negedge clk_i);
      check_value("debug_req_o", data_t'(debug_req_o), 32'h0);
      end_test("debug");
    end
  endtask

  initial begin
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    rtc_i          = 1'b0;
    wb_cyc_i       = 1'b0;
    wb_stb_i       = 1'b0;
    wb_we_i        = 1'b0;
    wb_adr_i       = '0;
    wb_dat_i       = '0;
    wb_sel_i       = '0;
    // debug request pending from the start
    debug_req_i    = 1'b1;
    expect_err     = 1'b0;
    lfsr           = 32'h1f0a;
    err_cnt        = 0;
    test_cnt       = 0;
    failed_tests   = 0;
    test_err_start = 0;
    repeat (10) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    run_rom_test();
    run_sram_test();
    run_unmapped_test();
    run_clint_test();
    run_debug_test();
    $display("summary: %0d tests, %0d failed, %0d errors", test_cnt, failed_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
